//--- build.f
design/life_pkg.sv
design/life_cell.sv
design/life_board_store.sv
design/life_row_drain.sv
design/life_engine.sv
sim/life_assertions.sv
sim/life_tb.sv

//--- design/life_board_store.sv
// Board store and generation sequencer
// Two register banks, host row loads, three-row window issue with vertical wrap
`timescale 1ns/1ns
`default_nettype none

module life_board_store import life_pkg::*; (
	input  wire              clk4,
	input  wire              reset,
	// Host row loads and step requests
	input  wire              load_valid,
	input  wire  row_idx_t   load_idx,
	input  wire  row_t       load_row,
	input  wire              step_valid,
	input  wire  gen_t       step_count,
	// From the drain
	input  wire              issue_ok,
	input  wire              wr_en,
	input  wire  row_idx_t   wr_idx,
	input  wire  row_t       wr_row,
	input  wire              gen_end,
	// Status and window out
	output logic             busy,
	output logic             win_valid,
	output row_idx_t         win_idx,
	output row_t             win_above,
	output row_t             win_mid,
	output row_t             win_below,
	output gen_t             gen_total
);

	row_t       banks [2][grid_rows];  // [bank][row]
	logic       bank_sel;              // Current bank, the other one is spare
	seq_state_t state;
	row_idx_t   row_ptr;               // Next row to issue
	gen_t       gens_left;             // Generations still to run
	row_idx_t   above_idx;
	row_idx_t   below_idx;
	logic       step_go;
	logic       issue;
	logic       last_row;

	////////////////////////////////////////
	// Request decode and window addressing
	////////////////////////////////////////

	assign busy     = (state != seq_idle);
	assign step_go  = step_valid && !busy && (step_count != '0);  // Zero count ignored
	assign issue    = issue_ok && (step_go || state == seq_run);  // First row goes with the step
	assign last_row = (row_ptr == row_idx_t'(grid_rows - 1));

	// Torus wrap top to bottom
	assign above_idx = (row_ptr == '0) ? row_idx_t'(grid_rows - 1) : row_ptr - 1'b1;
	assign below_idx = last_row ? '0 : row_ptr + 1'b1;

	////////////////////////////////////////
	// Bank storage
	////////////////////////////////////////

	always_ff @(posedge clk4) begin
		if (reset) begin
			for (int r = 0; r < grid_rows; r++) begin
				banks[0][r] <= '0;
				banks[1][r] <= '0;
			end
		end else begin
			if (load_valid && !busy) begin
				banks[bank_sel][load_idx] <= load_row;  // Host writes current board
			end
			if (wr_en) begin
				banks[!bank_sel][wr_idx] <= wr_row;     // New generation into spare
			end
		end
	end

	// Window rows, only meaningful with win_valid
	always_ff @(posedge clk4) begin
		if (issue) begin
			win_above <= banks[bank_sel][above_idx];
			win_mid   <= banks[bank_sel][row_ptr];
			win_below <= banks[bank_sel][below_idx];
		end
	end

	////////////////////////////////////////
	// Sequencer FSM
	////////////////////////////////////////

	always_ff @(posedge clk4) begin
		if (reset) begin
			state     <= seq_idle;
			row_ptr   <= '0;
			gens_left <= '0;
			gen_total <= '0;
			bank_sel  <= 1'b0;
			win_valid <= 1'b0;
			win_idx   <= '0;
		end else begin
			win_valid <= issue;
			if (issue) begin
				win_idx <= row_ptr;
				row_ptr <= last_row ? '0 : row_ptr + 1'b1;  // Back to row 0 for next gen
			end
			case (state)
				seq_idle: begin
					if (step_go) begin
						gens_left <= step_count;
						state     <= seq_run;
					end
				end
				seq_run: begin
					// Hold row position while no credit is free
					if (issue && last_row) begin
						state <= seq_wait;
					end
				end
				seq_wait: begin
					// Last row written back, spare bank now holds the new board
					if (gen_end) begin
						bank_sel  <= !bank_sel;
						gen_total <= gen_total + 1'b1;
						gens_left <= gens_left - 1'b1;
						state     <= (gens_left == gen_t'(1)) ? seq_idle : seq_run;
					end
				end
				default: state <= seq_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/life_cell.sv
// One column of the Life rule
// Counts the eight neighbours and registers the next state of the centre cell
`timescale 1ns/1ns
`default_nettype none

module life_cell (
	input  wire        clk4,
	input  wire        reset,
	// Bit 0 is column c-1, bit 1 column c, bit 2 column c+1
	input  wire  [2:0] above,
	input  wire  [2:0] mid,
	input  wire  [2:0] below,
	output logic       next_bit
);

	logic [3:0] count;  // 0 to 8 live neighbours
	logic       alive;

	// Centre of mid is the cell itself, not a neighbour
	always_comb begin
		count = {3'b0, above[0]} + {3'b0, above[1]} + {3'b0, above[2]}
			+ {3'b0, mid[0]} + {3'b0, mid[2]}
			+ {3'b0, below[0]} + {3'b0, below[1]} + {3'b0, below[2]};
	end

	// Birth on three, survival on two or three
	always_comb begin
		if (mid[1]) begin
			alive = (count == 4'd2) || (count == 4'd3);
		end else begin
			alive = (count == 4'd3);
		end
	end

	always_ff @(posedge clk4) begin
		if (reset) begin
			next_bit <= 1'b0;
		end else begin
			next_bit <= alive;  // Lines up with the drain input stage
		end
	end

endmodule

`default_nettype wire

//--- design/life_engine.sv
// Game of Life engine top
// Board store feeding one cell per column, drained through a credit-gated row stream
`timescale 1ns/1ns
`default_nettype none

module life_engine import life_pkg::*; (
	input  wire              clk4,
	input  wire              reset,
	// Host side
	input  wire              load_valid,
	input  wire  row_idx_t   load_idx,
	input  wire  row_t       load_row,
	input  wire              step_valid,
	input  wire  gen_t       step_count,
	input  wire              credit_return,
	// Status and row stream
	output logic             busy,
	output logic             out_valid,
	output row_idx_t         out_idx,
	output row_t             out_row,
	output gen_t             gen_total
);

	logic     win_valid;
	row_idx_t win_idx;
	row_t     win_above;
	row_t     win_mid;
	row_t     win_below;
	row_t     next_row;
	logic     issue_ok;
	logic     wr_en;
	row_idx_t wr_idx;
	row_t     wr_row;
	logic     gen_end;

	life_board_store store_i (
		.clk4       (clk4),
		.reset      (reset),
		.load_valid (load_valid),
		.load_idx   (load_idx),
		.load_row   (load_row),
		.step_valid (step_valid),
		.step_count (step_count),
		.issue_ok   (issue_ok),
		.wr_en      (wr_en),
		.wr_idx     (wr_idx),
		.wr_row     (wr_row),
		.gen_end    (gen_end),
		.busy       (busy),
		.win_valid  (win_valid),
		.win_idx    (win_idx),
		.win_above  (win_above),
		.win_mid    (win_mid),
		.win_below  (win_below),
		.gen_total  (gen_total)
	);

	////////////////////////////////////////
	// Cell array, wrap at columns 0 and 31
	////////////////////////////////////////

	for (genvar col = 0; col < grid_cols; col++) begin : g_col
		life_cell cell_i (
			.clk4     (clk4),
			.reset    (reset),
			.above    ({win_above[(col + 1) % grid_cols], win_above[col],
				win_above[(col + grid_cols - 1) % grid_cols]}),
			.mid      ({win_mid[(col + 1) % grid_cols], win_mid[col],
				win_mid[(col + grid_cols - 1) % grid_cols]}),
			.below    ({win_below[(col + 1) % grid_cols], win_below[col],
				win_below[(col + grid_cols - 1) % grid_cols]}),
			.next_bit (next_row[col])
		);
	end

	life_row_drain drain_i (
		.clk4          (clk4),
		.reset         (reset),
		.win_valid     (win_valid),
		.win_idx       (win_idx),
		.next_row      (next_row),
		.credit_return (credit_return),
		.issue_ok      (issue_ok),
		.wr_en         (wr_en),
		.wr_idx        (wr_idx),
		.wr_row        (wr_row),
		.gen_end       (gen_end),
		.out_valid     (out_valid),
		.out_idx       (out_idx),
		.out_row       (out_row)
	);

endmodule

`default_nettype wire

//--- design/life_pkg.sv
// Shared definitions for the Game of Life engine
// Board size, output credit depth, vector types and sequencer states
`default_nettype none

package life_pkg;

	////////////////////////////////////////
	// Board geometry
	////////////////////////////////////////

	localparam int grid_rows = 16;  // Board height, rows per generation
	localparam int grid_cols = 32;  // Board width, one cell unit per column

	// Rows the consumer can buffer
	localparam int out_credits = 4;

	////////////////////////////////////////
	// Vector types
	////////////////////////////////////////

	// One board row, bit n is column n
	typedef logic [grid_cols-1:0] row_t;

	// Row index within the board
	typedef logic [3:0] row_idx_t;

	// Generation count, requested and completed
	typedef logic [15:0] gen_t;

	// Credit counter, holds 0 to out_credits
	typedef logic [2:0] credit_t;

	////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////

	// Idle, issuing rows, or waiting for the last row to land
	typedef enum logic [1:0] {
		seq_idle = 2'd0,
		seq_run  = 2'd1,
		seq_wait = 2'd2
	} seq_state_t;

endpackage

`default_nettype wire

//--- design/life_row_drain.sv
// Row drain and credit keeper
// Writes new rows back to the spare bank, streams them out, gates issue on credits
`timescale 1ns/1ns
`default_nettype none

module life_row_drain import life_pkg::*; (
	input  wire              clk4,
	input  wire              reset,
	// Window side, one cycle ahead of next_row
	input  wire              win_valid,
	input  wire  row_idx_t   win_idx,
	input  wire  row_t       next_row,
	input  wire              credit_return,  // One pulse per returned row
	// To the feeder
	output logic             issue_ok,
	output logic             wr_en,
	output row_idx_t         wr_idx,
	output row_t             wr_row,
	output logic             gen_end,
	// Row stream out
	output logic             out_valid,
	output row_idx_t         out_idx,
	output row_t             out_row
);

	logic     next_valid;  // Matches the cell register
	row_idx_t next_idx;
	credit_t  credits;     // Free slots at the consumer
	credit_t  in_flight;   // Rows issued, not yet charged to credits

	////////////////////////////////////////
	// Input stage
	////////////////////////////////////////

	always_ff @(posedge clk4) begin
		if (reset) begin
			next_valid <= 1'b0;
			next_idx   <= '0;
		end else begin
			next_valid <= win_valid;
			next_idx   <= win_idx;
		end
	end

	// Write back the same cycle the row reaches the output register
	assign wr_en  = next_valid;
	assign wr_idx = next_idx;
	assign wr_row = next_row;

	////////////////////////////////////////
	// Output stage
	////////////////////////////////////////

	always_ff @(posedge clk4) begin
		if (reset) begin
			out_valid <= 1'b0;
			out_idx   <= '0;
			gen_end   <= 1'b0;
		end else begin
			out_valid <= next_valid;
			out_idx   <= next_idx;
			gen_end   <= next_valid && (next_idx == row_idx_t'(grid_rows - 1));  // Row 15 landed
		end
	end

	always_ff @(posedge clk4) begin
		out_row <= next_row;
	end

	////////////////////////////////////////
	// Credits
	////////////////////////////////////////

	// Window, cell and output stages each hold at most one row
	assign in_flight = credit_t'(win_valid) + credit_t'(next_valid) + credit_t'(out_valid);
	assign issue_ok  = (credits > in_flight);

	// Charged when the row leaves on out_valid
	always_ff @(posedge clk4) begin
		if (reset) begin
			credits <= credit_t'(out_credits);
		end else begin
			case ({out_valid, credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;  // Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compile and run the Game of Life testbench with Verilator

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module life_tb \
	-f build.f -Mdir "$obj_dir" -o life_sim > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$build_log"
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$obj_dir/life_sim" > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q -F "** FAIL **" "$sim_log"; then
	exit 1
fi
exit 0

//--- sim/life_assertions.sv
// Credit and handshake checks for the row drain
// Bound into every drain instance
`timescale 1ns/1ns
`default_nettype none

module life_assertions import life_pkg::*; (
	input  wire              clk4,
	input  wire              reset,
	input  wire              out_valid,
	input  wire              wr_en,
	input  wire              gen_end,
	input  wire  credit_t    credits
);

	// A row leaves only into a free consumer slot
	a_valid_has_credit: assert property (
		@(posedge clk4) disable iff (reset) out_valid |-> (credits != '0))
		else $error("out_valid while the credit count is zero");

	// Returns never push the count past the consumer depth
	a_credit_ceiling: assert property (
		@(posedge clk4) disable iff (reset) credits <= credit_t'(out_credits))
		else $error("credit count above out_credits");

	// Clean state on the first cycle out of reset
	a_reset_state: assert property (
		@(posedge clk4) $fell(reset) |->
			(!out_valid && !wr_en && !gen_end && credits == credit_t'(out_credits)))
		else $error("drain outputs or credits not at reset values");

endmodule

bind life_row_drain life_assertions drain_checks_i (
	.clk4      (clk4),
	.reset     (reset),
	.out_valid (out_valid),
	.wr_en     (wr_en),
	.gen_end   (gen_end),
	.credits   (credits)
);

`default_nettype wire

//--- sim/life_tb.sv
// Testbench for the Game of Life engine
// Directed tests against a torus reference model with a credit-paced consumer
`timescale 1ns/1ns
`default_nettype none

module life_tb import life_pkg::*; ();

	localparam int total_gens = 24;    // Sum of step counts over all tests
	localparam int clk_period = 20;
	localparam int watchdog_cycles = total_gens * grid_rows * 8 + 2000;  // 8 per row plus margin

	logic        clk4;
	logic        reset;
	logic        load_valid;
	row_idx_t    load_idx;
	row_t        load_row;
	logic        step_valid;
	gen_t        step_count;
	logic        credit_return = 1'b0;
	logic        busy;
	logic        out_valid;
	row_idx_t    out_idx;
	row_t        out_row;
	gen_t        gen_total;

	row_t        model [grid_rows];          // Reference board
	row_t        last_gen [grid_rows];       // Final generation as streamed by the DUT
	logic [31:0] lfsr = 32'hf1d8_0669;
	row_idx_t    rx_idx [$];                 // Streamed rows in arrival order
	row_t        rx_row [$];
	int          return_every = 1;           // Consumer pace in cycles
	int          outstanding = 0;            // Rows held without a credit return
	int          gap = 0;
	int          errors = 0;
	int          errors_at_start = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	gen_t        gen_expect = '0;

	life_engine life_engine_i (
		.clk4          (clk4),
		.reset         (reset),
		.load_valid    (load_valid),
		.load_idx      (load_idx),
		.load_row      (load_row),
		.step_valid    (step_valid),
		.step_count    (step_count),
		.credit_return (credit_return),
		.busy          (busy),
		.out_valid     (out_valid),
		.out_idx       (out_idx),
		.out_row       (out_row),
		.gen_total     (gen_total)
	);

	initial begin
		clk4 = 1'b0;
		forever #(clk_period / 2) clk4 = ~clk4;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("Watchdog expired after %0d cycles, run stopped", watchdog_cycles);
		$display("** FAIL **");
		$finish;
	end

	////////////////////////////////////////
	// Consumer sampling mid-cycle
	////////////////////////////////////////

	always @(negedge clk4) begin
		if (reset) begin
			outstanding   = 0;
			gap           = 0;
			credit_return = 1'b0;
		end else begin
			credit_return = 1'b0;
			if (out_valid) begin
				rx_idx.push_back(out_idx);
				rx_row.push_back(out_row);
				outstanding++;
			end
			if (outstanding > out_credits) begin
				$display("Error: %0d rows held without a credit return", outstanding);
				errors++;
			end
			gap++;
			if (outstanding > 0 && gap >= return_every) begin
				credit_return = 1'b1;  // One credit back
				outstanding--;
				gap = 0;
			end
		end
	end

	////////////////////////////////////////
	// Reference model and stimulus source
	////////////////////////////////////////

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic cell_at(input int r, input int c);
		return model[(r + grid_rows) % grid_rows][(c + grid_cols) % grid_cols];  // Torus
	endfunction

	// One generation of the whole board
	task automatic advance_model();
		row_t nb [grid_rows];
		int   n;
		for (int r = 0; r < grid_rows; r++) begin
			for (int c = 0; c < grid_cols; c++) begin
				n = 0;
				for (int dr = -1; dr <= 1; dr++) begin
					for (int dc = -1; dc <= 1; dc++) begin
						if (dr != 0 || dc != 0) begin
							n = n + int'(cell_at(r + dr, c + dc));
						end
					end
				end
				nb[r][c] = (n == 3) || (cell_at(r, c) && n == 2);  // Birth on 3 and survival on 2 or 3
			end
		end
		model = nb;
	endtask

	////////////////////////////////////////
	// Checks and reporting
	////////////////////////////////////////

	task automatic check_row(input string name, input row_t exp, input row_t act);
		if (act !== exp) begin
			$display("Fail %s: expected row %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_idx(input string name, input row_idx_t exp, input row_idx_t act);
		if (act !== exp) begin
			$display("Fail %s: expected index %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_gen(input string name, input gen_t exp, input gen_t act);
		if (act !== exp) begin
			$display("Fail %s: expected gen_total %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic flag_error(input string name, input string what);
		$display("Error in %s: %s", name, what);
		errors++;
	endtask

	task automatic start_test();
		errors_at_start = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - errors_at_start);
		end
	endtask

	////////////////////////////////////////
	// Host sequences
	////////////////////////////////////////

	task automatic load_board();
		for (int r = 0; r < grid_rows; r++) begin
			@(negedge clk4);
			load_valid = 1'b1;
			load_idx   = row_idx_t'(r);
			load_row   = model[r];
		end
		@(negedge clk4);
		load_valid = 1'b0;
	endtask

	// Load the model board, step, check every streamed row, then busy and gen_total
	task automatic step_and_check(input string name, input int gens);
		row_idx_t idx;
		row_t     row;
		int       waited;
		load_board();
		rx_idx.delete();
		rx_row.delete();
		step_valid = 1'b1;
		step_count = gen_t'(gens);
		@(negedge clk4);
		step_valid = 1'b0;
		gen_expect = gen_expect + gen_t'(gens);
		for (int g = 0; g < gens; g++) begin
			advance_model();
			for (int r = 0; r < grid_rows; r++) begin
				while (rx_row.size() == 0) @(negedge clk4);
				idx = rx_idx.pop_front();
				row = rx_row.pop_front();
				last_gen[r] = row;
				check_idx(name, row_idx_t'(r), idx);
				check_row(name, model[r], row);
			end
		end
		waited = 0;
		while (busy && waited < 8) begin
			@(negedge clk4);
			waited++;
		end
		if (busy) flag_error(name, "busy still high after the final row");
		check_gen(name, gen_expect, gen_total);
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic test_reset_zero();
		start_test();
		if (busy !== 1'b0 || out_valid !== 1'b0) begin
			flag_error("reset_zero", "busy or out_valid high after reset");
		end
		check_gen("reset_zero", '0, gen_total);
		for (int r = 0; r < grid_rows; r++) model[r] = '0;
		step_and_check("reset_zero", 1);
		end_test("reset_zero");
	endtask

	task automatic test_still_osc();
		start_test();
		for (int r = 0; r < grid_rows; r++) model[r] = '0;
		model[5] = 32'h0000_0018;  // 2x2 block at columns 3 and 4
		model[6] = 32'h0000_0018;
		step_and_check("block", 3);
		// Block must come back unchanged from the DUT
		for (int r = 0; r < grid_rows; r++) begin
			check_row("block", (r == 5 || r == 6) ? 32'h0000_0018 : '0, last_gen[r]);
		end
		for (int r = 0; r < grid_rows; r++) model[r] = '0;
		model[7] = 32'h0000_0400;  // Vertical blinker in column 10
		model[8] = 32'h0000_0400;
		model[9] = 32'h0000_0400;
		step_and_check("blinker", 4);
		end_test("still_osc");
	endtask

	task automatic test_glider_wrap();
		start_test();
		for (int r = 0; r < grid_rows; r++) model[r] = '0;
		model[15] = 32'h8000_0000;  // Straddles both board edges
		model[0]  = 32'h0000_0001;
		model[1]  = 32'hc000_0001;
		step_and_check("glider_wrap", 8);
		end_test("glider_wrap");
	endtask

	task automatic fill_random();
		for (int r = 0; r < grid_rows; r++) begin
			for (int c = 0; c < grid_cols; c++) model[r][c] = lfsr_bit();
		end
	endtask

	task automatic test_random();
		start_test();
		fill_random();
		step_and_check("random", 5);
		end_test("random");
	endtask

	task automatic test_back_pressure();
		start_test();
		return_every = 7;  // Slow consumer
		fill_random();
		step_and_check("back_pressure", 3);
		return_every = 1;
		end_test("back_pressure");
	endtask

	// Zero count is ignored and leaves the total unchanged
	task automatic test_gen_total();
		start_test();
		rx_row.delete();
		rx_idx.delete();
		@(negedge clk4);
		step_valid = 1'b1;
		step_count = '0;
		@(negedge clk4);
		step_valid = 1'b0;
		repeat (6) begin
			@(negedge clk4);
			if (busy) flag_error("gen_total", "zero step count started a run");
		end
		if (rx_row.size() != 0) flag_error("gen_total", "rows streamed without a run");
		check_gen("gen_total", gen_expect, gen_total);
		end_test("gen_total");
	endtask

	initial begin
		reset      = 1'b1;
		load_valid = 1'b0;
		load_idx   = '0;
		load_row   = '0;
		step_valid = 1'b0;
		step_count = '0;
		repeat (16) @(negedge clk4);
		reset = 1'b0;
		@(negedge clk4);
		test_reset_zero();
		test_still_osc();
		test_glider_wrap();
		test_random();
		test_back_pressure();
		test_gen_total();
		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire
